/* dv/epd_sva.sv */
`timescale 1ns/10ps
module epd_sva (
    input logic clk,
    input logic rst,
    input logic cfg_req,
    input logic cfg_ack,
    input logic b_trigger,
    input logic vin_ready,
    input logic vin_valid,
    input logic bi_ready,
    input logic bi_valid,
    input logic epd_gdoe,
    input logic epd_gdsp
);

    localparam int TRIG_CYCLES  = int'(panel_timing_pkg::VS_DELAY) + 1;
    localparam int READY_CYCLES = int'(panel_timing_pkg::H_ACT) * int'(panel_timing_pkg::V_ACT);
    localparam int GDSP_CYCLES  = int'(panel_timing_pkg::V_SYNC) * int'(panel_timing_pkg::H_TOTAL);

    int unsigned fail_count = 0;
    int          trig_len;
    int          gdsp_len;
    int          ready_len;

    // Run lengths of the frame strobes
    always_ff @(posedge clk) begin
        if (rst) begin
            trig_len  <= 0;
            gdsp_len  <= 0;
            ready_len <= 0;
        end else begin
            trig_len <= b_trigger ? trig_len + 1 : 0;
            gdsp_len <= epd_gdsp ? 0 : gdsp_len + 1;
            if (b_trigger) begin
                ready_len <= 0;
            end else if (vin_ready) begin
                ready_len <= ready_len + 1;
            end
        end
    end

    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(cfg_ack) |-> $past(cfg_req))
        else begin $error("cfg_ack rose without cfg_req"); fail_count++; end

    ack_holds: assert property (@(posedge clk) disable iff (rst)
        (cfg_req && cfg_ack) |=> cfg_ack)
        else begin $error("cfg_ack dropped while cfg_req was high"); fail_count++; end

    ack_drops: assert property (@(posedge clk) disable iff (rst)
        $fell(cfg_req) |=> !cfg_ack)
        else begin $error("cfg_ack did not fall after cfg_req fell"); fail_count++; end

    trig_length: assert property (@(posedge clk) disable iff (rst)
        $fell(b_trigger) |-> (trig_len == TRIG_CYCLES))
        else begin $error("b_trigger pulse has the wrong length"); fail_count++; end

    // Vertical sync window on the gate start pulse
    gdsp_length: assert property (@(posedge clk) disable iff (rst)
        $rose(epd_gdsp) |-> (gdsp_len == GDSP_CYCLES))
        else begin $error("epd_gdsp low time is wrong"); fail_count++; end

    ready_per_frame: assert property (@(posedge clk) disable iff (rst)
        $fell(epd_gdoe) |-> (ready_len == READY_CYCLES))
        else begin $error("wrong number of ready cycles in a frame"); fail_count++; end

    vin_valid_with_ready: assert property (@(posedge clk) disable iff (rst)
        vin_ready |-> vin_valid)
        else begin $error("vin_ready high without vin_valid"); fail_count++; end

    bi_valid_with_ready: assert property (@(posedge clk) disable iff (rst)
        bi_ready |-> bi_valid)
        else begin $error("bi_ready high without bi_valid"); fail_count++; end

endmodule

/* dv/tb_epd.sv */
`timescale 1ns/10ps
module tb_epd;

    localparam int CLK_HALF      = 10;
    localparam int RESET_CYCLES  = 16;
    localparam int NUM_FRAMES    = 4;
    localparam int LUT_WORDS     = 2**waveform_pkg::LUT_WR_AW;
    localparam int LUT_SIZE      = 2**$bits(waveform_pkg::lut_rd_addr_t);
    localparam int FRAME_PIXELS  = int'(panel_timing_pkg::H_ACT) * int'(panel_timing_pkg::V_ACT);
    localparam int FRAME_CYCLES  = int'(panel_timing_pkg::VS_DELAY) + 1
                                   + int'(panel_timing_pkg::H_TOTAL) * int'(panel_timing_pkg::V_TOTAL);
    // Four clocks per handshake write, plus reset and settling
    localparam int CFG_CYCLES    = (LUT_WORDS + 1) * 4 + RESET_CYCLES + 8;
    localparam int WATCHDOG_CYCLES = 2 * NUM_FRAMES * FRAME_CYCLES + CFG_CYCLES;

    logic                  clk;
    logic                  rst;
    logic                  sys_ready;
    logic                  vin_vsync;
    logic [31:0]           vin_pixel = '0;
    logic                  vin_valid = 1'b0;
    logic                  vin_ready;
    logic                  b_trigger;
    logic [63:0]           bi_pixel = '0;
    logic                  bi_valid = 1'b0;
    logic                  bi_ready;
    logic [63:0]           bo_pixel;
    logic                  bo_valid;
    logic                  cfg_req;
    waveform_pkg::cfg_wr_t cfg;
    logic                  cfg_ack;
    logic                  epd_gdoe;
    logic                  epd_gdclk;
    logic                  epd_gdsp;
    logic                  epd_sdclk;
    logic                  epd_sdle;
    logic                  epd_sdoe;
    logic                  epd_sdce0;
    logic [7:0]            epd_sd;

    // Reference copy of the waveform table and length
    waveform_pkg::drive_t  lut_model [LUT_SIZE];
    waveform_pkg::frame_t  frames_model = '0;
    logic [7:0]            exp_sd_q [$];
    logic [63:0]           exp_bo_q [$];
    int                    errors = 0;
    int                    words_checked = 0;
    int                    n_idle = 0;
    int                    n_start = 0;
    int                    n_run = 0;
    logic                  vsync_seen = 1'b0;

    epd_top u_epd_top (.*);

    bind epd_top epd_sva u_sva (
        .clk       (clk),
        .rst       (rst),
        .cfg_req   (cfg_req),
        .cfg_ack   (cfg_ack),
        .b_trigger (b_trigger),
        .vin_ready (vin_ready),
        .vin_valid (vin_valid),
        .bi_ready  (bi_ready),
        .bi_valid  (bi_valid),
        .epd_gdoe  (epd_gdoe),
        .epd_gdsp  (epd_gdsp)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // Drive, src and fcnt expected for one pixel, as {drive, state}
    function automatic logic [17:0] expect_pixel(input logic [3:0] lum, input logic [15:0] st);
        logic [3:0] src;
        logic [5:0] fcnt;
        logic [3:0] tgt;
        logic [5:0] fseq;
        src  = st[13:10];
        fcnt = st[9:4];
        tgt  = st[3:0];
        fseq = frames_model - fcnt;
        if (fcnt != 6'd0) begin
            return {lut_model[{fseq, tgt, src}], 2'b00, src, fcnt - 6'd1, tgt};
        end
        if (lum != tgt) begin
            return {2'b00, 2'b00, tgt, frames_model, lum};
        end
        return {2'b00, 2'b00, src, fcnt, tgt};
    endfunction

    // Biased so idle, start and running pixels all show up
    function automatic logic [15:0] random_state(input logic [3:0] lum);
        logic [3:0] src;
        logic [3:0] tgt;
        logic [5:0] fcnt;
        src  = 4'($urandom);
        tgt  = ($urandom_range(0, 1) == 0) ? lum : 4'($urandom);
        fcnt = 6'd0;
        if (frames_model != 6'd0 && $urandom_range(0, 2) != 0) begin
            fcnt = 6'($urandom_range(1, 32'(frames_model)));
        end
        return {2'b00, src, fcnt, tgt};
    endfunction

    task automatic write_cfg(input waveform_pkg::cfg_sel_t sel, input logic [11:0] addr,
                             input logic [7:0] data);
        cfg.sel  <= sel;
        cfg.addr <= addr;
        cfg.data <= data;
        cfg_req  <= 1'b1;
        @(posedge clk);
        while (!cfg_ack) @(posedge clk);
        cfg_req <= 1'b0;
        @(posedge clk);
        while (cfg_ack) @(posedge clk);
    endtask

    task automatic run_frame();
        int seen;
        vin_vsync <= 1'b1;
        @(posedge clk);
        vin_vsync <= 1'b0;
        while (!b_trigger) @(posedge clk);
        while (b_trigger) @(posedge clk);
        // Source streams carry data only while the scan runs
        vin_valid <= 1'b1;
        bi_valid  <= 1'b1;
        seen = 0;
        while (seen < FRAME_PIXELS) begin
            @(posedge clk);
            if (vin_ready) begin
                seen++;
            end
        end
        // Frame ends when the output enables drop after the last line
        while (epd_gdoe) @(posedge clk);
        vin_valid <= 1'b0;
        bi_valid  <= 1'b0;
    endtask

    // Output checks, expectation queue and fresh input data each clock
    always @(posedge clk) begin : pixel_stream
        logic [7:0]  exp_sd;
        logic [63:0] exp_bo;
        logic [31:0] new_pix;
        logic [63:0] new_state;
        logic [17:0] res;
        logic [3:0]  lum;
        logic [15:0] st;
        if (!rst) begin
            if (!vsync_seen) begin
                assert (!b_trigger && !vin_ready && !bi_ready && !bo_valid && !epd_gdoe
                        && !epd_sdoe && !epd_sdle && !epd_gdclk && !epd_sdclk && epd_gdsp
                        && epd_sdce0 && epd_sd == 8'h00)
                else begin
                    errors++;
                    $display("error %0t ns: panel output active before the first vsync", $time);
                end
            end
            if (vin_vsync) begin
                vsync_seen = 1'b1;
            end
            assert (bo_valid == !epd_sdce0)
            else begin
                errors++;
                $display("error %0t ns: bo_valid %b with epd_sdce0 %b", $time, bo_valid, epd_sdce0);
            end
            if (bo_valid && exp_sd_q.size() == 0) begin
                errors++;
                $display("Output word appeared at %0t ns with nothing expected", $time);
            end else if (bo_valid) begin
                exp_sd = exp_sd_q.pop_front();
                exp_bo = exp_bo_q.pop_front();
                words_checked++;
                assert (epd_sd == exp_sd)
                else begin
                    errors++;
                    $display("error %0t ns: epd_sd %h, expected %h", $time, epd_sd, exp_sd);
                end
                assert (bo_pixel == exp_bo)
                else begin
                    errors++;
                    $display("error %0t ns: bo_pixel %h, expected %h", $time, bo_pixel, exp_bo);
                end
            end else begin
                assert (epd_sd == 8'h00)
                else begin
                    errors++;
                    $display("error %0t ns: epd_sd %h outside active pixels", $time, epd_sd);
                end
            end
            if (vin_ready) begin
                exp_sd = '0;
                exp_bo = '0;
                for (int i = 0; i < waveform_pkg::PIX_PER_CLK; i++) begin
                    lum = vin_pixel[8*i+4 +: 4];
                    st  = bi_pixel[16*i +: 16];
                    if (st[9:4] != 6'd0) begin
                        n_run++;
                    end else if (lum != st[3:0]) begin
                        n_start++;
                    end else begin
                        n_idle++;
                    end
                    res = expect_pixel(lum, st);
                    exp_sd[2*i +: 2]   = res[17:16];
                    exp_bo[16*i +: 16] = res[15:0];
                end
                exp_sd_q.push_back(exp_sd);
                exp_bo_q.push_back(exp_bo);
            end
        end
        for (int i = 0; i < waveform_pkg::PIX_PER_CLK; i++) begin
            lum = 4'($urandom);
            new_pix[8*i +: 8]    = {lum, 4'($urandom)};
            new_state[16*i +: 16] = random_state(lum);
        end
        vin_pixel <= new_pix;
        bi_pixel  <= new_state;
    end

    initial begin : main_seq
        logic [7:0] data;
        int         sva_fails;
        void'($urandom(32'hc30691fe));
        rst       <= 1'b1;
        sys_ready <= 1'b0;
        vin_vsync <= 1'b0;
        cfg_req   <= 1'b0;
        cfg       <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst       <= 1'b0;
        sys_ready <= 1'b1;
        repeat (4) @(posedge clk);
        // Whole table, four entries per write
        for (int word = 0; word < LUT_WORDS; word++) begin
            data = 8'($urandom);
            for (int k = 0; k < 4; k++) begin
                lut_model[{word[11:0], k[1:0]}] = data[2*k +: 2];
            end
            write_cfg(waveform_pkg::CFG_LUT, word[11:0], data);
        end
        frames_model = 6'($urandom_range(1, 63));
        write_cfg(waveform_pkg::CFG_FRAMES, 12'h000, {2'b00, frames_model});
        for (int f = 0; f < NUM_FRAMES; f++) begin
            run_frame();
        end
        if (exp_sd_q.size() != 0) begin
            errors++;
            $display("%0d expected output words never appeared", exp_sd_q.size());
        end
        if (n_idle == 0 || n_start == 0 || n_run == 0) begin
            errors++;
            $display("Not every pixel case was exercised by the stimulus");
        end
        sva_fails = int'(u_epd_top.u_sva.fail_count);
        $display("Words %0d, pixels idle %0d start %0d running %0d, errors %0d, sva errors %0d",
                 words_checked, n_idle, n_start, n_run, errors, sva_fails);
        if (errors == 0 && sva_fails == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout, the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("Test FAILED");
        $finish;
    end

endmodule

/* hdl/cfg_port.sv */
`timescale 1ns/10ps
module cfg_port (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cfg_req,
    input  waveform_pkg::cfg_wr_t cfg,
    output logic                  cfg_ack,
    output waveform_pkg::lut_wr_t lut_wr,
    output waveform_pkg::frame_t  lut_frames
);

    logic wr_stb;

    // Request seen but not yet acknowledged
    assign wr_stb = cfg_req && !cfg_ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg_ack    <= 1'b0;
            lut_frames <= '0;
        end else begin
            cfg_ack <= cfg_req;
            if (wr_stb && (cfg.sel == waveform_pkg::CFG_FRAMES)) begin
                lut_frames <= cfg.data[5:0];
            end
        end
    end

    // Table write lands on the same edge that raises ack
    always_comb begin
        lut_wr.en   = wr_stb && (cfg.sel == waveform_pkg::CFG_LUT);
        lut_wr.addr = cfg.addr;
        lut_wr.data = cfg.data;
    end

endmodule

/* hdl/epd_signal_gen.sv */
`timescale 1ns/10ps
module epd_signal_gen (
    input  logic                          clk,
    input  logic                          rst,
    input  panel_timing_pkg::scan_phase_t phase,
    output logic                          epd_gdoe,
    output logic                          epd_gdclk,
    output logic                          epd_gdsp,
    output logic                          epd_sdclk,
    output logic                          epd_sdle,
    output logic                          epd_sdoe,
    output logic                          epd_sdce0
);

    logic gdclk_pre;

    assign epd_gdoe  = phase.in_vsync || phase.in_vbp || phase.in_vact;
    assign epd_sdoe  = epd_gdoe;
    assign epd_gdsp  = !phase.in_vsync;
    assign epd_sdle  = phase.running && phase.in_hsync;
    assign epd_sdce0 = !(phase.in_vact && phase.in_hact);

    // Gate clock lags the line phases by one clock
    assign gdclk_pre = phase.running && (phase.in_hsync || phase.in_hbp || phase.in_hact);

    always_ff @(posedge clk) begin
        if (rst) begin
            epd_gdclk <= 1'b0;
        end else begin
            epd_gdclk <= gdclk_pre;
        end
    end

    // Source clock runs everywhere except back porch
    assign epd_sdclk = (phase.running && (phase.in_hfp || phase.in_hsync || phase.in_hact))
                       ? ~clk : 1'b0;

endmodule

/* hdl/epd_top.sv */
`timescale 1ns/10ps
module epd_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  sys_ready,
    // Image input, four Y8 pixels per clock
    input  logic                  vin_vsync,
    input  logic [31:0]           vin_pixel,
    input  logic                  vin_valid,
    output logic                  vin_ready,
    // Framebuffer state in and out
    output logic                  b_trigger,
    input  logic [63:0]           bi_pixel,
    input  logic                  bi_valid,
    output logic                  bi_ready,
    output logic [63:0]           bo_pixel,
    output logic                  bo_valid,
    // Configuration handshake
    input  logic                  cfg_req,
    input  waveform_pkg::cfg_wr_t cfg,
    output logic                  cfg_ack,
    // Panel drivers
    output logic                  epd_gdoe,
    output logic                  epd_gdclk,
    output logic                  epd_gdsp,
    output logic                  epd_sdclk,
    output logic                  epd_sdle,
    output logic                  epd_sdoe,
    output logic                  epd_sdce0,
    output logic [7:0]            epd_sd
);

    panel_timing_pkg::scan_phase_t phase;
    waveform_pkg::lut_wr_t         lut_wr;
    waveform_pkg::frame_t          lut_frames;
    logic                          accept;

    // Streams cannot stall, so valid is only checked by the assertions
    assign vin_ready = accept;
    assign bi_ready  = accept;

    cfg_port u_cfg_port (
        .clk        (clk),
        .rst        (rst),
        .cfg_req    (cfg_req),
        .cfg        (cfg),
        .cfg_ack    (cfg_ack),
        .lut_wr     (lut_wr),
        .lut_frames (lut_frames)
    );

    scan_timing u_scan_timing (
        .clk       (clk),
        .rst       (rst),
        .sys_ready (sys_ready),
        .vin_vsync (vin_vsync),
        .phase     (phase),
        .b_trigger (b_trigger),
        .accept    (accept)
    );

    epd_signal_gen u_signal_gen (
        .clk       (clk),
        .rst       (rst),
        .phase     (phase),
        .epd_gdoe  (epd_gdoe),
        .epd_gdclk (epd_gdclk),
        .epd_gdsp  (epd_gdsp),
        .epd_sdclk (epd_sdclk),
        .epd_sdle  (epd_sdle),
        .epd_sdoe  (epd_sdoe),
        .epd_sdce0 (epd_sdce0)
    );

    pixel_pipeline u_pixel_pipeline (
        .clk        (clk),
        .rst        (rst),
        .accept     (accept),
        .vin_pixel  (vin_pixel),
        .bi_pixel   (bi_pixel),
        .lut_frames (lut_frames),
        .lut_wr     (lut_wr),
        .epd_sd     (epd_sd),
        .bo_pixel   (bo_pixel),
        .bo_valid   (bo_valid)
    );

endmodule

/* hdl/panel_timing_pkg.sv */
package panel_timing_pkg;

    localparam int CNT_W = 11;

    // Vertical phases, counted in lines
    localparam logic [CNT_W-1:0] V_FP    = CNT_W'(3);
    localparam logic [CNT_W-1:0] V_SYNC  = CNT_W'(1);
    localparam logic [CNT_W-1:0] V_BP    = CNT_W'(2);
    localparam logic [CNT_W-1:0] V_ACT   = CNT_W'(16);
    localparam logic [CNT_W-1:0] V_TOTAL = V_FP + V_SYNC + V_BP + V_ACT;

    // Horizontal phases, counted in clocks of four pixels
    localparam logic [CNT_W-1:0] H_FP    = CNT_W'(2);
    localparam logic [CNT_W-1:0] H_SYNC  = CNT_W'(1);
    localparam logic [CNT_W-1:0] H_BP    = CNT_W'(2);
    localparam logic [CNT_W-1:0] H_ACT   = CNT_W'(16);
    localparam logic [CNT_W-1:0] H_TOTAL = H_FP + H_SYNC + H_BP + H_ACT;

    localparam logic [CNT_W-1:0] VS_DELAY  = CNT_W'(8);
    localparam logic [CNT_W-1:0] PIPE_LEAD = CNT_W'(3);

    // Vertical flags imply running; horizontal flags are a plain column decode
    typedef struct packed {
        logic running;
        logic in_vsync;
        logic in_vbp;
        logic in_vact;
        logic in_hfp;
        logic in_hsync;
        logic in_hbp;
        logic in_hact;
    } scan_phase_t;

endpackage

/* hdl/pixel_pipeline.sv */
`timescale 1ns/10ps
module pixel_pipeline (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  accept,
    input  logic [31:0]           vin_pixel,
    input  logic [63:0]           bi_pixel,
    input  waveform_pkg::frame_t  lut_frames,
    input  waveform_pkg::lut_wr_t lut_wr,
    output logic [7:0]            epd_sd,
    output logic [63:0]           bo_pixel,
    output logic                  bo_valid
);

    waveform_pkg::lum_t         s1_lum    [waveform_pkg::PIX_PER_CLK];
    waveform_pkg::pix_state_t   s1_state  [waveform_pkg::PIX_PER_CLK];
    waveform_pkg::lum_t         s2_lum    [waveform_pkg::PIX_PER_CLK];
    waveform_pkg::pix_state_t   s2_state  [waveform_pkg::PIX_PER_CLK];
    waveform_pkg::lut_rd_addr_t rd_addr   [waveform_pkg::PIX_PER_CLK];
    waveform_pkg::drive_t       rd_drive  [waveform_pkg::PIX_PER_CLK];
    waveform_pkg::drive_t       upd_drive [waveform_pkg::PIX_PER_CLK];
    waveform_pkg::pix_state_t   upd_state [waveform_pkg::PIX_PER_CLK];
    logic [7:0]                 drive_bus;
    logic                       s1_valid;
    logic                       s2_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            bo_valid <= 1'b0;
            epd_sd   <= '0;
        end else begin
            s1_valid <= accept;
            s2_valid <= s1_valid;
            bo_valid <= s2_valid;
            epd_sd   <= s2_valid ? drive_bus : '0;
        end
    end

    // Stage 1, keep only the upper nibble of each Y8 pixel
    always_ff @(posedge clk) begin
        if (accept) begin
            for (int i = 0; i < waveform_pkg::PIX_PER_CLK; i++) begin
                s1_lum[i]   <= vin_pixel[8*i+4 +: 4];
                s1_state[i] <= bi_pixel[16*i +: 16];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < waveform_pkg::PIX_PER_CLK; i++) begin
            rd_addr[i].fseq = lut_frames - s1_state[i].fcnt;
            rd_addr[i].tgt  = s1_state[i].tgt;
            rd_addr[i].src  = s1_state[i].src;
        end
    end

    waveform_lut u_lut (
        .clk      (clk),
        .lut_wr   (lut_wr),
        .rd_addr  (rd_addr),
        .rd_drive (rd_drive)
    );

    // Stage 2, payload follows the table read
    always_ff @(posedge clk) begin
        s2_lum   <= s1_lum;
        s2_state <= s1_state;
    end

    for (genvar i = 0; i < waveform_pkg::PIX_PER_CLK; i++) begin : g_pix
        pixel_update u_update (
            .lum_in     (s2_lum[i]),
            .state_in   (s2_state[i]),
            .lut_drive  (rd_drive[i]),
            .lut_frames (lut_frames),
            .drive      (upd_drive[i]),
            .state_out  (upd_state[i])
        );
        assign drive_bus[2*i +: 2] = upd_drive[i];
    end

    // Stage 3, writeback word
    always_ff @(posedge clk) begin
        for (int i = 0; i < waveform_pkg::PIX_PER_CLK; i++) begin
            bo_pixel[16*i +: 16] <= upd_state[i];
        end
    end

endmodule

/* hdl/pixel_update.sv */
`timescale 1ns/10ps
module pixel_update (
    input  waveform_pkg::lum_t       lum_in,
    input  waveform_pkg::pix_state_t state_in,
    input  waveform_pkg::drive_t     lut_drive,
    input  waveform_pkg::frame_t     lut_frames,
    output waveform_pkg::drive_t     drive,
    output waveform_pkg::pix_state_t state_out
);

    always_comb begin
        state_out      = state_in;
        state_out.rsvd = '0;
        drive          = '0;
        if (state_in.fcnt != '0) begin
            // Transition in progress
            drive          = lut_drive;
            state_out.fcnt = state_in.fcnt - 1'b1;
        end else if (lum_in != state_in.tgt) begin
            // New target, restart the waveform from the old target
            state_out.src  = state_in.tgt;
            state_out.tgt  = lum_in;
            state_out.fcnt = lut_frames;
        end
    end

endmodule

/* hdl/scan_timing.sv */
`timescale 1ns/10ps
module scan_timing (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           sys_ready,
    input  logic                           vin_vsync,
    output panel_timing_pkg::scan_phase_t  phase,
    output logic                           b_trigger,
    output logic                           accept
);

    typedef enum logic [1:0] {
        SCAN_IDLE,
        SCAN_WAITING,
        SCAN_RUNNING
    } scan_state_t;

    scan_state_t                        state;
    logic [panel_timing_pkg::CNT_W-1:0] h_cnt;
    logic [panel_timing_pkg::CNT_W-1:0] v_cnt;
    logic                               running;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= SCAN_IDLE;
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            case (state)
                SCAN_IDLE: begin
                    h_cnt <= '0;
                    v_cnt <= '0;
                    if (sys_ready && vin_vsync) begin
                        state <= SCAN_WAITING;
                    end
                end
                // h_cnt doubles as the delay counter here
                SCAN_WAITING: begin
                    if (h_cnt == panel_timing_pkg::VS_DELAY) begin
                        state <= SCAN_RUNNING;
                        h_cnt <= '0;
                    end else begin
                        h_cnt <= h_cnt + 1'b1;
                    end
                end
                SCAN_RUNNING: begin
                    if (h_cnt == panel_timing_pkg::H_TOTAL - 1'b1) begin
                        h_cnt <= '0;
                        if (v_cnt == panel_timing_pkg::V_TOTAL - 1'b1) begin
                            state <= SCAN_IDLE;
                            v_cnt <= '0;
                        end else begin
                            v_cnt <= v_cnt + 1'b1;
                        end
                    end else begin
                        h_cnt <= h_cnt + 1'b1;
                    end
                end
                default: state <= SCAN_IDLE;
            endcase
        end
    end

    assign running   = (state == SCAN_RUNNING);
    assign b_trigger = (state == SCAN_WAITING);

    always_comb begin
        phase.running  = running;
        phase.in_vsync = running && (v_cnt >= panel_timing_pkg::V_FP)
                         && (v_cnt < panel_timing_pkg::V_FP + panel_timing_pkg::V_SYNC);
        phase.in_vbp   = running
                         && (v_cnt >= panel_timing_pkg::V_FP + panel_timing_pkg::V_SYNC)
                         && (v_cnt < panel_timing_pkg::V_TOTAL - panel_timing_pkg::V_ACT);
        phase.in_vact  = running
                         && (v_cnt >= panel_timing_pkg::V_TOTAL - panel_timing_pkg::V_ACT);
        phase.in_hfp   = (h_cnt < panel_timing_pkg::H_FP);
        phase.in_hsync = (h_cnt >= panel_timing_pkg::H_FP)
                         && (h_cnt < panel_timing_pkg::H_FP + panel_timing_pkg::H_SYNC);
        phase.in_hbp   = (h_cnt >= panel_timing_pkg::H_FP + panel_timing_pkg::H_SYNC)
                         && (h_cnt < panel_timing_pkg::H_TOTAL - panel_timing_pkg::H_ACT);
        phase.in_hact  = (h_cnt >= panel_timing_pkg::H_TOTAL - panel_timing_pkg::H_ACT);
    end

    // Active window shifted early by the pipeline depth
    assign accept = phase.in_vact
        && (h_cnt >= panel_timing_pkg::H_TOTAL - panel_timing_pkg::H_ACT
                     - panel_timing_pkg::PIPE_LEAD)
        && (h_cnt < panel_timing_pkg::H_TOTAL - panel_timing_pkg::PIPE_LEAD);

endmodule

/* hdl/waveform_lut.sv */
`timescale 1ns/10ps
module waveform_lut (
    input  logic                       clk,
    input  waveform_pkg::lut_wr_t      lut_wr,
    input  waveform_pkg::lut_rd_addr_t rd_addr  [waveform_pkg::PIX_PER_CLK],
    output waveform_pkg::drive_t       rd_drive [waveform_pkg::PIX_PER_CLK]
);

    waveform_pkg::drive_t mem [2**$bits(waveform_pkg::lut_rd_addr_t)];

    // Entry k of the write word sits at the two lowest address bits
    always_ff @(posedge clk) begin
        if (lut_wr.en) begin
            for (int k = 0; k < 4; k++) begin
                mem[{lut_wr.addr, k[1:0]}] <= lut_wr.data[2*k +: 2];
            end
        end
    end

    // Four independent read ports, one clock of latency
    always_ff @(posedge clk) begin
        for (int i = 0; i < waveform_pkg::PIX_PER_CLK; i++) begin
            rd_drive[i] <= mem[rd_addr[i]];
        end
    end

endmodule

/* hdl/waveform_pkg.sv */
package waveform_pkg;

    localparam int PIX_PER_CLK = 4;
    localparam int LUT_WR_AW   = 12;

    typedef logic [3:0] lum_t;
    typedef logic [5:0] frame_t;
    typedef logic [1:0] drive_t;

    // Per-pixel state word as stored in the framebuffer
    typedef struct packed {
        logic [1:0] rsvd;
        lum_t       src;
        frame_t     fcnt;
        lum_t       tgt;
    } pix_state_t;

    // 16K entry table, indexed by frame sequence and grey level pair
    typedef struct packed {
        frame_t fseq;
        lum_t   tgt;
        lum_t   src;
    } lut_rd_addr_t;

    typedef enum logic {
        CFG_LUT    = 1'b0,
        CFG_FRAMES = 1'b1
    } cfg_sel_t;

    typedef struct packed {
        cfg_sel_t             sel;
        logic [LUT_WR_AW-1:0] addr;
        logic [7:0]           data;
    } cfg_wr_t;

    // One write carries four 2-bit entries
    typedef struct packed {
        logic                 en;
        logic [LUT_WR_AW-1:0] addr;
        logic [7:0]           data;
    } lut_wr_t;

endpackage

/* run.sh */
#!/usr/bin/env bash
# Compile and run the EPD controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module tb_epd -Mdir obj_dir -o sim_epd -f tb.f
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

# Assertion failures must not stop the run before the testbench reports
./obj_dir/sim_epd +verilator+error+limit+1000 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test FAILED" "$log"; then
    exit 1
fi
exit 0

/* tb.f */
hdl/panel_timing_pkg.sv
hdl/waveform_pkg.sv
hdl/cfg_port.sv
hdl/scan_timing.sv
hdl/epd_signal_gen.sv
hdl/waveform_lut.sv
hdl/pixel_update.sv
hdl/pixel_pipeline.sv
hdl/epd_top.sv
dv/epd_sva.sv
dv/tb_epd.sv
